//--- CoherentCacheSlice.f
+incdir+verilog
verilog/coherencePkg.sv
verilog/Arbiter.sv
verilog/TagStateStore.sv
verilog/ConcurrencyLock.sv
verilog/CpuController.sv
verilog/SnoopController.sv
verilog/CoherentCacheSlice.sv
verif/CoherentCacheSliceTb.sv

//--- verif/coherenceTrace.txt
// kind addr wdata snoopCmd fill expCpuData expBusCmd expSnoopData expInvalidated
// kind 1 read 2 write 3 snoop 4 write+snoop 5 write+snoop in grant, 0 ends the trace
1 0010 00000000 0 a5a50001 a5a50001 1 00000000 0
1 0010 00000000 0 00000000 a5a50001 0 00000000 0
2 0010 11110001 0 00000000 11110001 3 00000000 0
2 0024 22220002 0 0badf00d 22220002 2 00000000 0
1 0024 00000000 0 00000000 22220002 0 00000000 0
1 0010 00000000 0 00000000 11110001 0 00000000 0
3 0010 00000000 1 00000000 00000000 0 11110001 0
2 0010 33330003 0 00000000 33330003 3 00000000 0
3 0024 00000000 3 00000000 00000000 0 22220002 1
1 0024 00000000 0 44440004 44440004 1 00000000 0
3 0024 00000000 2 00000000 00000000 0 00000000 1
1 0024 00000000 0 55550005 55550005 1 00000000 0
3 0100 00000000 1 00000000 00000000 0 00000000 0
4 0010 66660006 2 00000000 66660006 0 66660006 1
1 0010 00000000 0 77770007 77770007 1 00000000 0
1 0038 00000000 0 88880008 88880008 1 00000000 0
5 0038 99990009 3 00000000 99990009 3 00000000 1
1 0038 00000000 0 00000000 99990009 0 00000000 0
0 0000 00000000 0 00000000 00000000 0 00000000 0

//--- verif/CoherentCacheSliceTb.sv
`default_nettype none

`include "coherence_cfg.svh"

module CoherentCacheSliceTb;
	timeunit 1ns;
	timeprecision 100ps;

	import coherencePkg::*;

	localparam int FIELDS = 9;
	localparam int MAX_LINES = 32;

	logic clock = 0;
	logic rst;
	logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress;
	cacheWord cpuDataOut;
	logic cpuReadEnabled;
	logic cpuWriteEnabled;
	cacheWord cpuDataIn;
	logic cpuFunctionComplete;
	logic busRequest;
	busCommand busCommandOut;
	logic [`ADDRESS_WIDTH - 1 : 0] busAddressOut;
	logic busGrant;
	logic busDone;
	cacheWord busDataIn;
	busCommand snoopCommandIn;
	logic [`ADDRESS_WIDTH - 1 : 0] snoopAddressIn;
	cacheWord snoopDataOut;
	logic snoopIsInvalidated;
	logic snoopComplete;

	logic [31:0] traceMem [MAX_LINES * FIELDS];
	logic [31:0] lfsr;
	int cycleCount = 0;
	int cycleLimit = 0;
	int lineCount;

	CoherentCacheSlice u_dut (
		.clock(clock),
		.rst(rst),
		.cpuAddress(cpuAddress),
		.cpuDataOut(cpuDataOut),
		.cpuReadEnabled(cpuReadEnabled),
		.cpuWriteEnabled(cpuWriteEnabled),
		.cpuDataIn(cpuDataIn),
		.cpuFunctionComplete(cpuFunctionComplete),
		.busRequest(busRequest),
		.busCommandOut(busCommandOut),
		.busAddressOut(busAddressOut),
		.busGrant(busGrant),
		.busDone(busDone),
		.busDataIn(busDataIn),
		.snoopCommandIn(snoopCommandIn),
		.snoopAddressIn(snoopAddressIn),
		.snoopDataOut(snoopDataOut),
		.snoopIsInvalidated(snoopIsInvalidated),
		.snoopComplete(snoopComplete)
	);

	always #10 clock = ~clock;

	// limit set once the trace length is known
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout: the trace did not finish within %0d cycles", cycleLimit);
			$display("Verification failed");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h8020_0003;
		end
		return next;
	endfunction

	// two lfsr bits give a bus delay of 0 to 3 cycles
	task automatic pickDelay(output int delay);
		delay = 0;
		for (int i = 0; i < 2; i++) begin
			delay = (delay << 1) | lfsr[0];
			lfsr = lfsrStep(lfsr);
		end
	endtask

	// outputs sampled and inputs driven 2 ns after the edge
	task automatic nextCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic awaitGrant();
		do begin
			@(posedge clock);
			#1;
		end while (!busGrant);
		#1;
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkWord(input string name, input cacheWord expected, input cacheWord actual);
		if (actual !== expected) begin
			abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic checkCommand(input string name, input busCommand expected,
			input busCommand actual);
		if (actual !== expected) begin
			abortRun($sformatf("MISMATCH %s expected %s actual %s (%0d)", name,
				expected.name(), actual.name(), actual));
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abortRun($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic checkAddress(input string name,
			input logic [`ADDRESS_WIDTH - 1 : 0] expected,
			input logic [`ADDRESS_WIDTH - 1 : 0] actual);
		if (actual !== expected) begin
			abortRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// grant then done with the fill word
	task automatic serveBus(input cacheWord fill, input logic holdForSnoop);
		int delay;
		logic snoopSeen;
		snoopSeen = 0;
		pickDelay(delay);
		repeat (delay) nextCycle();
		busGrant = 1;
		// looped snoop has to arrive while the grant is up
		while (holdForSnoop && !snoopSeen) begin
			nextCycle();
			snoopSeen = snoopComplete;
		end
		pickDelay(delay);
		repeat (delay) nextCycle();
		busDone = 1;
		busDataIn = fill;
		nextCycle();
		busDone = 0;
		busGrant = 0;
		busDataIn = '0;
	endtask

	task automatic runCpu(input string name, input logic isWrite,
			input logic [`ADDRESS_WIDTH - 1 : 0] address, input cacheWord writeData,
			input cacheWord fill, input cacheWord expData, input busCommand expCommand,
			input logic holdForSnoop);
		logic served;
		int cycles;
		served = 0;
		cycles = 0;
		cpuAddress = address;
		cpuDataOut = writeData;
		cpuReadEnabled = !isWrite;
		cpuWriteEnabled = isWrite;
		do begin
			nextCycle();
			cycles++;
			if (busRequest && !served) begin
				served = 1;
				checkCommand({name, " bus command"}, expCommand, busCommandOut);
				checkAddress({name, " bus address"}, address, busAddressOut);
				serveBus(fill, holdForSnoop);
			end
		end while (!cpuFunctionComplete);
		if (!served) begin
			checkCommand({name, " bus command"}, expCommand, NONE);
			if (cycles != 1) begin
				abortRun($sformatf("%s: hit completed %0d cycles after the enable instead of 1",
					name, cycles));
			end
		end
		checkWord({name, " cpu data"}, expData, cpuDataIn);
		nextCycle();
		cpuReadEnabled = 0;
		cpuWriteEnabled = 0;
	endtask

	task automatic runSnoop(input string name, input busCommand command,
			input logic [`ADDRESS_WIDTH - 1 : 0] address, input cacheWord expData,
			input logic expInvalidated, input logic afterGrant);
		if (afterGrant) begin
			awaitGrant();
		end
		snoopCommandIn = command;
		snoopAddressIn = address;
		do begin
			nextCycle();
		end while (!snoopComplete);
		checkWord({name, " snoop data"}, expData, snoopDataOut);
		checkFlag({name, " invalidated"}, expInvalidated, snoopIsInvalidated);
		nextCycle();
		snoopCommandIn = NONE;
	endtask

	function automatic string kindName(input logic [3:0] kind);
		case (kind)
			1: return "cpu read";
			2: return "cpu write";
			3: return "snoop";
			4: return "write with snoop";
			5: return "write with looped snoop";
			default: return "unknown";
		endcase
	endfunction

	initial begin
		int base;
		string name;
		logic [3:0] kind;
		logic [`ADDRESS_WIDTH - 1 : 0] address;
		cacheWord writeData;
		busCommand snoopCommand;
		cacheWord fill;
		cacheWord expCpuData;
		busCommand expCommand;
		cacheWord expSnoopData;
		logic expInvalidated;
		rst = 1;
		cpuAddress = '0;
		cpuDataOut = '0;
		cpuReadEnabled = 0;
		cpuWriteEnabled = 0;
		busGrant = 0;
		busDone = 0;
		busDataIn = '0;
		snoopCommandIn = NONE;
		snoopAddressIn = '0;
		lfsr = 66466;
		for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
			traceMem[i] = '0;
		end
		$readmemh("verif/coherenceTrace.txt", traceMem);
		lineCount = 0;
		while (lineCount < MAX_LINES && traceMem[lineCount * FIELDS] != 0) begin
			lineCount++;
		end
		if (lineCount == 0) begin
			abortRun("the trace file holds no operations");
		end
		cycleLimit = 16 + 24 * lineCount;
		repeat (16) @(posedge clock);
		#2;
		rst = 0;
		checkFlag("reset cpuFunctionComplete", 1'b0, cpuFunctionComplete);
		checkFlag("reset busRequest", 1'b0, busRequest);
		checkFlag("reset snoopComplete", 1'b0, snoopComplete);
		checkFlag("reset snoopIsInvalidated", 1'b0, snoopIsInvalidated);
		for (int line = 0; line < lineCount; line++) begin
			base = line * FIELDS;
			kind = traceMem[base][3:0];
			address = traceMem[base + 1][`ADDRESS_WIDTH - 1 : 0];
			writeData = traceMem[base + 2];
			snoopCommand = busCommand'(traceMem[base + 3][2:0]);
			fill = traceMem[base + 4];
			expCpuData = traceMem[base + 5];
			expCommand = busCommand'(traceMem[base + 6][2:0]);
			expSnoopData = traceMem[base + 7];
			expInvalidated = traceMem[base + 8][0];
			name = $sformatf("line %0d %s", line + 1, kindName(kind));
			// idle gap so no grant is still held from the last operation
			repeat (2) nextCycle();
			case (kind)
				1: runCpu(name, 0, address, writeData, fill, expCpuData, expCommand, 0);
				2: runCpu(name, 1, address, writeData, fill, expCpuData, expCommand, 0);
				3: runSnoop(name, snoopCommand, address, expSnoopData, expInvalidated, 0);
				4: begin
					fork
						runCpu(name, 1, address, writeData, fill, expCpuData, expCommand, 0);
						runSnoop(name, snoopCommand, address, expSnoopData, expInvalidated, 0);
					join
				end
				5: begin
					fork
						runCpu(name, 1, address, writeData, fill, expCpuData, expCommand, 1);
						runSnoop(name, snoopCommand, address, expSnoopData, expInvalidated, 1);
					join
				end
				default: abortRun($sformatf("%s: unknown operation kind %0d", name, kind));
			endcase
		end
		$display("Verification passed");
		$finish;
	end

endmodule : CoherentCacheSliceTb

`default_nettype wire

//--- verilog/CoherentCacheSlice.sv
`default_nettype none

`include "coherence_cfg.svh"

module CoherentCacheSlice (
	input  logic clock,
	input  logic rst,
	input  logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress,
	input  coherencePkg::cacheWord cpuDataOut,
	input  logic cpuReadEnabled,
	input  logic cpuWriteEnabled,
	output coherencePkg::cacheWord cpuDataIn,
	output logic cpuFunctionComplete,
	output logic busRequest,
	output coherencePkg::busCommand busCommandOut,
	output logic [`ADDRESS_WIDTH - 1 : 0] busAddressOut,
	input  logic busGrant,
	input  logic busDone,
	input  coherencePkg::cacheWord busDataIn,
	input  coherencePkg::busCommand snoopCommandIn,
	input  logic [`ADDRESS_WIDTH - 1 : 0] snoopAddressIn,
	output coherencePkg::cacheWord snoopDataOut,
	output logic snoopIsInvalidated,
	output logic snoopComplete
);
	import coherencePkg::*;

	logic gatedReadEnabled;
	logic gatedWriteEnabled;
	busCommand gatedSnoopCommand;
	logic lockedGrant;
	logic snoopLoop;
	logic invalidateRequired;

	// store ports
	logic cpuHit;
	mesiState cpuState;
	cacheWord cpuReadData;
	logic snoopHit;
	mesiState snoopState;
	cacheWord snoopReadData;
	logic cpuWrite;
	cacheWord cpuWriteData;
	logic cpuFill;
	cacheWord cpuFillData;
	mesiState cpuNewState;
	logic snoopUpdate;
	mesiState snoopNewState;

	ConcurrencyLock lock (
		.clock(clock),
		.rst(rst),
		.cpuAddress(cpuAddress),
		.cpuReadEnabled(cpuReadEnabled),
		.cpuWriteEnabled(cpuWriteEnabled),
		.cpuCommandOut(busCommandOut),
		.busGrantIn(busGrant),
		.snoopCommandIn(snoopCommandIn),
		.snoopAddress(snoopAddressIn),
		.cpuHit(cpuHit),
		.snoopHit(snoopHit),
		.invalidateRequired(invalidateRequired),
		.gatedReadEnabled(gatedReadEnabled),
		.gatedWriteEnabled(gatedWriteEnabled),
		.gatedSnoopCommand(gatedSnoopCommand),
		.busGrantOut(lockedGrant),
		.snoopLoop(snoopLoop)
	);

	TagStateStore store (
		.clock(clock),
		.rst(rst),
		.cpuAddress(cpuAddress),
		.snoopAddress(snoopAddressIn),
		.cpuWrite(cpuWrite),
		.cpuWriteData(cpuWriteData),
		.cpuFill(cpuFill),
		.cpuFillData(cpuFillData),
		.cpuNewState(cpuNewState),
		.snoopUpdate(snoopUpdate),
		.snoopNewState(snoopNewState),
		.cpuHit(cpuHit),
		.cpuState(cpuState),
		.cpuReadData(cpuReadData),
		.snoopHit(snoopHit),
		.snoopState(snoopState),
		.snoopReadData(snoopReadData)
	);

	CpuController cpuController (
		.clock(clock),
		.rst(rst),
		.cpuAddress(cpuAddress),
		.cpuDataOut(cpuDataOut),
		.gatedReadEnabled(gatedReadEnabled),
		.gatedWriteEnabled(gatedWriteEnabled),
		.cpuHit(cpuHit),
		.cpuState(cpuState),
		.cpuReadData(cpuReadData),
		.busGrant(lockedGrant),
		.busDone(busDone),
		.busDataIn(busDataIn),
		.cpuDataIn(cpuDataIn),
		.cpuFunctionComplete(cpuFunctionComplete),
		.invalidateRequired(invalidateRequired),
		.busRequest(busRequest),
		.busCommandOut(busCommandOut),
		.busAddressOut(busAddressOut),
		.cpuWrite(cpuWrite),
		.cpuWriteData(cpuWriteData),
		.cpuFill(cpuFill),
		.cpuFillData(cpuFillData),
		.cpuNewState(cpuNewState)
	);

	SnoopController snoopController (
		.clock(clock),
		.rst(rst),
		.gatedSnoopCommand(gatedSnoopCommand),
		.snoopLoop(snoopLoop),
		.snoopHit(snoopHit),
		.snoopState(snoopState),
		.snoopReadData(snoopReadData),
		.snoopUpdate(snoopUpdate),
		.snoopNewState(snoopNewState),
		.snoopDataOut(snoopDataOut),
		.snoopIsInvalidated(snoopIsInvalidated),
		.snoopComplete(snoopComplete)
	);

endmodule : CoherentCacheSlice

`default_nettype wire

//--- verilog/SnoopController.sv
`default_nettype none

module SnoopController (
	input  logic clock,
	input  logic rst,
	input  coherencePkg::busCommand gatedSnoopCommand,
	input  logic snoopLoop,
	input  logic snoopHit,
	input  coherencePkg::mesiState snoopState,
	input  coherencePkg::cacheWord snoopReadData,
	output logic snoopUpdate,
	output coherencePkg::mesiState snoopNewState,
	output coherencePkg::cacheWord snoopDataOut,
	output logic snoopIsInvalidated,
	output logic snoopComplete
);
	import coherencePkg::*;

	typedef enum logic [1:0] {SNOOP_IDLE, SNOOP_LOOKUP, SNOOP_DONE} snoopPhase;

	snoopPhase phase;
	busCommand command;
	logic loopSeen;
	logic isRead;
	logic dirtyHit;

	assign isRead   = command == BUS_READ;
	assign dirtyHit = snoopHit && snoopState == MODIFIED;

	// reads downgrade dirty lines and ownership requests drop any copy
	assign snoopUpdate   = phase == SNOOP_LOOKUP && !loopSeen && (isRead ? dirtyHit : snoopHit);
	assign snoopNewState = isRead ? SHARED : INVALID;
	assign snoopComplete = phase == SNOOP_DONE;

	always_ff @(posedge clock) begin
		if (rst) begin
			phase              <= SNOOP_IDLE;
			command            <= NONE;
			loopSeen           <= 0;
			snoopIsInvalidated <= 0;
		end else begin
			case (phase)
				SNOOP_IDLE: begin
					if (gatedSnoopCommand inside {BUS_READ, BUS_READ_EXCLUSIVE, BUS_INVALIDATE}) begin
						phase    <= SNOOP_LOOKUP;
						command  <= gatedSnoopCommand;
						loopSeen <= snoopLoop;
					end
				end
				SNOOP_LOOKUP: begin
					phase              <= SNOOP_DONE;
					snoopIsInvalidated <= loopSeen || (snoopHit && !isRead);
				end
				default: begin
					phase              <= SNOOP_IDLE;
					snoopIsInvalidated <= 0;
				end
			endcase
		end
	end

	// only a dirty copy supplies data
	always_ff @(posedge clock) begin
		if (phase == SNOOP_LOOKUP) begin
			snoopDataOut <= (dirtyHit && !loopSeen) ? snoopReadData : '0;
		end
	end

endmodule : SnoopController

`default_nettype wire

//--- verilog/CpuController.sv
`default_nettype none

`include "coherence_cfg.svh"

module CpuController (
	input  logic clock,
	input  logic rst,
	input  logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress,
	input  coherencePkg::cacheWord cpuDataOut,
	input  logic gatedReadEnabled,
	input  logic gatedWriteEnabled,
	input  logic cpuHit,
	input  coherencePkg::mesiState cpuState,
	input  coherencePkg::cacheWord cpuReadData,
	input  logic busGrant,
	input  logic busDone,
	input  coherencePkg::cacheWord busDataIn,
	output coherencePkg::cacheWord cpuDataIn,
	output logic cpuFunctionComplete,
	output logic invalidateRequired,
	output logic busRequest,
	output coherencePkg::busCommand busCommandOut,
	output logic [`ADDRESS_WIDTH - 1 : 0] busAddressOut,
	output logic cpuWrite,
	output coherencePkg::cacheWord cpuWriteData,
	output logic cpuFill,
	output coherencePkg::cacheWord cpuFillData,
	output coherencePkg::mesiState cpuNewState
);
	import coherencePkg::*;

	typedef enum logic [1:0] {CPU_IDLE, CPU_BUS, CPU_DONE} cpuPhase;

	cpuPhase phase;
	logic pendingWrite;
	logic writeHit;
	logic fillNow;

	assign writeHit = phase == CPU_IDLE && gatedWriteEnabled && cpuHit && cpuState == MODIFIED;
	assign fillNow  = phase == CPU_BUS && busGrant && busDone;

	// shared copy must be invalidated elsewhere before writing
	assign invalidateRequired  = cpuHit && cpuState == SHARED;
	assign cpuFunctionComplete = phase == CPU_DONE;

	assign cpuWrite     = writeHit;
	assign cpuWriteData = cpuDataOut;
	assign cpuFill      = fillNow;
	// one word per line, so a write miss keeps only the cpu word
	assign cpuFillData  = pendingWrite ? cpuDataOut : busDataIn;
	assign cpuNewState  = (phase == CPU_BUS && !pendingWrite) ? SHARED : MODIFIED;

	always_ff @(posedge clock) begin
		if (rst) begin
			phase         <= CPU_IDLE;
			busRequest    <= 0;
			busCommandOut <= NONE;
			pendingWrite  <= 0;
		end else begin
			case (phase)
				CPU_IDLE: begin
					if ((gatedReadEnabled && cpuHit) || writeHit) begin
						phase <= CPU_DONE;
					end else if (gatedReadEnabled || gatedWriteEnabled) begin
						phase        <= CPU_BUS;
						busRequest   <= 1;
						pendingWrite <= gatedWriteEnabled;
						if (!gatedWriteEnabled) begin
							busCommandOut <= BUS_READ;
						end else if (cpuHit) begin
							busCommandOut <= BUS_INVALIDATE;
						end else begin
							busCommandOut <= BUS_READ_EXCLUSIVE;
						end
					end
				end
				CPU_BUS: begin
					if (fillNow) begin
						phase      <= CPU_DONE;
						busRequest <= 0;
					end
				end
				default: phase <= CPU_IDLE;
			endcase
		end
	end

	// returned word and bus address
	always_ff @(posedge clock) begin
		if (phase == CPU_IDLE) begin
			cpuDataIn     <= gatedReadEnabled ? cpuReadData : cpuDataOut;
			busAddressOut <= cpuAddress;
		end else if (fillNow) begin
			cpuDataIn <= cpuFillData;
		end
	end

endmodule : CpuController

`default_nettype wire

//--- verilog/ConcurrencyLock.sv
`default_nettype none

`include "coherence_cfg.svh"

module ConcurrencyLock (
	input  logic clock,
	input  logic rst,
	input  logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress,
	input  logic cpuReadEnabled,
	input  logic cpuWriteEnabled,
	input  coherencePkg::busCommand cpuCommandOut,
	input  logic busGrantIn,
	input  coherencePkg::busCommand snoopCommandIn,
	input  logic [`ADDRESS_WIDTH - 1 : 0] snoopAddress,
	input  logic cpuHit,
	input  logic snoopHit,
	input  logic invalidateRequired,
	output logic gatedReadEnabled,
	output logic gatedWriteEnabled,
	output coherencePkg::busCommand gatedSnoopCommand,
	output logic busGrantOut,
	output logic snoopLoop
);
	import coherencePkg::*;

	logic sameBlock;
	logic snoopCoherent;
	logic snoopTakesOwnership;
	logic conflict;
	logic cpuRequest;
	logic cpuGrant;
	logic snoopGrant;
	logic cpuHold;
	logic snoopHold;

	assign sameBlock = cpuAddress[`ADDRESS_WIDTH - 1 : `OFFSET_WIDTH] ==
		snoopAddress[`ADDRESS_WIDTH - 1 : `OFFSET_WIDTH];

	assign snoopTakesOwnership = snoopCommandIn == BUS_INVALIDATE ||
		snoopCommandIn == BUS_READ_EXCLUSIVE;
	// writeback is never coherent traffic
	assign snoopCoherent = snoopCommandIn == BUS_READ || snoopTakesOwnership;

	always_comb begin
		snoopLoop = 0;
		conflict  = 0;
		// our own granted command seen again on the snoop port
		if (sameBlock && busGrantIn &&
				((cpuCommandOut == BUS_INVALIDATE && snoopCommandIn == BUS_INVALIDATE) ||
				(cpuCommandOut == BUS_READ_EXCLUSIVE && snoopCommandIn == BUS_READ_EXCLUSIVE))) begin
			snoopLoop = 1;
		end else if (sameBlock && cpuHit && snoopHit) begin
			// reads clash with ownership requests, local writes with anything
			if (cpuReadEnabled && snoopTakesOwnership) begin
				conflict = 1;
			end else if (cpuWriteEnabled && !invalidateRequired && snoopCoherent) begin
				conflict = 1;
			end
		end
	end

	assign cpuRequest = cpuReadEnabled || cpuWriteEnabled;

	Arbiter arbiter (
		.clock(clock),
		.rst(rst),
		.cpuRequest(cpuRequest),
		.snoopRequest(snoopCoherent),
		.cpuGrant(cpuGrant),
		.snoopGrant(snoopGrant)
	);

	// only the loser of a real conflict is held
	assign cpuHold   = conflict && !cpuGrant;
	assign snoopHold = conflict && !snoopGrant;

	assign gatedReadEnabled  = cpuHold ? 1'b0 : cpuReadEnabled;
	assign gatedWriteEnabled = cpuHold ? 1'b0 : cpuWriteEnabled;
	assign gatedSnoopCommand = snoopHold ? NONE : snoopCommandIn;

	assign busGrantOut = busGrantIn;

endmodule : ConcurrencyLock

`default_nettype wire

//--- verilog/TagStateStore.sv
`default_nettype none

`include "coherence_cfg.svh"

module TagStateStore (
	input  logic clock,
	input  logic rst,
	input  logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress,
	input  logic [`ADDRESS_WIDTH - 1 : 0] snoopAddress,
	input  logic cpuWrite,
	input  coherencePkg::cacheWord cpuWriteData,
	input  logic cpuFill,
	input  coherencePkg::cacheWord cpuFillData,
	input  coherencePkg::mesiState cpuNewState,
	input  logic snoopUpdate,
	input  coherencePkg::mesiState snoopNewState,
	output logic cpuHit,
	output coherencePkg::mesiState cpuState,
	output coherencePkg::cacheWord cpuReadData,
	output logic snoopHit,
	output coherencePkg::mesiState snoopState,
	output coherencePkg::cacheWord snoopReadData
);
	import coherencePkg::*;

	localparam int TAG_LOW = `OFFSET_WIDTH + `INDEX_WIDTH;

	blockTag  tagArray [`LINE_COUNT];
	mesiState stateArray [`LINE_COUNT];
	cacheWord dataArray [`LINE_COUNT];

	logic [`INDEX_WIDTH - 1 : 0] cpuIndex;
	logic [`INDEX_WIDTH - 1 : 0] snoopIndex;
	blockTag cpuTag;
	blockTag snoopTag;

	assign cpuIndex   = cpuAddress[TAG_LOW - 1 : `OFFSET_WIDTH];
	assign snoopIndex = snoopAddress[TAG_LOW - 1 : `OFFSET_WIDTH];
	assign cpuTag     = cpuAddress[`ADDRESS_WIDTH - 1 : TAG_LOW];
	assign snoopTag   = snoopAddress[`ADDRESS_WIDTH - 1 : TAG_LOW];

	// cpu side lookup
	assign cpuState    = stateArray[cpuIndex];
	assign cpuHit      = cpuState != INVALID && tagArray[cpuIndex] == cpuTag;
	assign cpuReadData = dataArray[cpuIndex];

	// snoop side lookup
	assign snoopState    = stateArray[snoopIndex];
	assign snoopHit      = snoopState != INVALID && tagArray[snoopIndex] == snoopTag;
	assign snoopReadData = dataArray[snoopIndex];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `LINE_COUNT; i++) begin
				stateArray[i] <= INVALID;
			end
		end else begin
			if (cpuFill || cpuWrite) begin
				stateArray[cpuIndex] <= cpuNewState;
			end
			// later assignment, so snoop wins a shared index
			if (snoopUpdate) begin
				stateArray[snoopIndex] <= snoopNewState;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (cpuFill) begin
			tagArray[cpuIndex]  <= cpuTag;
			dataArray[cpuIndex] <= cpuFillData;
		end else if (cpuWrite) begin
			dataArray[cpuIndex] <= cpuWriteData;
		end
	end

endmodule : TagStateStore

`default_nettype wire

//--- verilog/Arbiter.sv
`default_nettype none

module Arbiter (
	input  logic clock,
	input  logic rst,
	input  logic cpuRequest,
	input  logic snoopRequest,
	output logic cpuGrant,
	output logic snoopGrant
);

	logic cpuHeld;
	logic snoopHeld;
	logic lastWasCpu;

	always_comb begin
		cpuGrant   = 0;
		snoopGrant = 0;
		// current owner keeps the grant until its request drops
		if (cpuHeld && cpuRequest) begin
			cpuGrant = 1;
		end else if (snoopHeld && snoopRequest) begin
			snoopGrant = 1;
		end else if (cpuRequest && snoopRequest) begin
			// tie goes to whoever did not win last
			cpuGrant   = ~lastWasCpu;
			snoopGrant = lastWasCpu;
		end else begin
			cpuGrant   = cpuRequest;
			snoopGrant = snoopRequest;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			cpuHeld    <= 0;
			snoopHeld  <= 0;
			lastWasCpu <= 0;
		end else begin
			cpuHeld   <= cpuGrant;
			snoopHeld <= snoopGrant;
			if (cpuGrant) begin
				lastWasCpu <= 1;
			end else if (snoopGrant) begin
				lastWasCpu <= 0;
			end
		end
	end

endmodule : Arbiter

`default_nettype wire

//--- verilog/coherencePkg.sv
`default_nettype none

`include "coherence_cfg.svh"

package coherencePkg;

	// commands driven onto and snooped from the shared bus
	typedef enum logic [2:0] {
		NONE,
		BUS_READ,
		BUS_READ_EXCLUSIVE,
		BUS_INVALIDATE,
		BUS_WRITEBACK
	} busCommand;

	// MSI subset of the line states
	typedef enum logic [1:0] {
		INVALID,
		SHARED,
		MODIFIED
	} mesiState;

	typedef logic [`DATA_WIDTH - 1 : 0] cacheWord;

	// address bits above index and offset
	typedef logic [`ADDRESS_WIDTH - `OFFSET_WIDTH - `INDEX_WIDTH - 1 : 0] blockTag;

endpackage : coherencePkg

`default_nettype wire

//--- verilog/coherence_cfg.svh
`ifndef COHERENCE_CFG_SVH
`define COHERENCE_CFG_SVH

// word address seen by the cpu and on the bus
`define ADDRESS_WIDTH 16

// block offset bits, blocks compare above these
`define OFFSET_WIDTH 2

// set index bits of the direct-mapped store
`define INDEX_WIDTH 3
`define LINE_COUNT (1 << `INDEX_WIDTH)

`define DATA_WIDTH 32

`endif
